// ==== filelist.f ====
+incdir+verif
source/core_pkg.sv
source/core_ifs.sv
source/ifu.sv
source/idu.sv
source/regfile.sv
source/exu.sv
source/lsu.sv
source/mem_xbar.sv
source/core_top.sv
verif/core_tb.sv

// ==== run.sh ====
#!/bin/bash
# Builds the core testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -j 0 --top-module core_tb -f filelist.f -o core_sim &&
	./obj_dir/core_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }

// ==== verif/test_program.svh ====
task automatic load_program();
	word_t skip;

	skip = enc_i(12'h001, 5'd0, 3'b000, 5'd5, 7'b0010011);  // addi x5, x0, 1 on skipped paths
	mem[0]  = enc_u(20'h12345, 5'd1, 7'b0110111);             // lui x1
	mem[1]  = enc_u(20'h00001, 5'd2, 7'b0010111);             // auipc x2
	mem[2]  = enc_i(12'hffb, 5'd0, 3'b000, 5'd3, 7'b0010011); // addi x3, x0, -5
	mem[3]  = enc_i(12'h007, 5'd0, 3'b000, 5'd4, 7'b0010011); // addi x4, x0, 7
	mem[4]  = enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd5);         // add x5, x3, x4
	mem[5]  = enc_r(7'h20, 5'd3, 5'd4, 3'b000, 5'd6);         // sub x6, x4, x3
	mem[6]  = enc_r(7'h00, 5'd3, 5'd1, 3'b111, 5'd7);         // and x7, x1, x3
	mem[7]  = enc_r(7'h00, 5'd2, 5'd4, 3'b110, 5'd8);         // or x8, x4, x2
	mem[8]  = enc_r(7'h00, 5'd4, 5'd1, 3'b100, 5'd9);         // xor x9, x1, x4
	mem[9]  = enc_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd10);        // slt x10, x3, x4
	mem[10] = enc_r(7'h00, 5'd4, 5'd3, 3'b011, 5'd11);        // sltu x11, x3, x4
	mem[11] = enc_r(7'h00, 5'd4, 5'd4, 3'b001, 5'd12);        // sll x12, x4, x4
	mem[12] = enc_r(7'h00, 5'd4, 5'd3, 3'b101, 5'd13);        // srl x13, x3, x4
	mem[13] = enc_r(7'h20, 5'd4, 5'd3, 3'b101, 5'd14);        // sra x14, x3, x4
	mem[14] = enc_i(12'h003, 5'd4, 3'b001, 5'd12, 7'b0010011); // slli x12, x4, 3
	mem[15] = enc_i(12'h401, 5'd3, 3'b101, 5'd13, 7'b0010011); // srai x13, x3, 1
	mem[16] = enc_s(12'h100, 5'd1, 5'd0);                     // sw x1, 0x100(x0)
	mem[17] = enc_i(12'h100, 5'd0, 3'b010, 5'd15, 7'b0000011); // lw x15, 0x100(x0)
	mem[18] = enc_b(13'h008, 5'd1, 5'd15, 3'b000);            // beq x15, x1 taken
	mem[19] = skip;
	mem[20] = enc_b(13'h008, 5'd4, 5'd5, 3'b001);             // bne x5, x4 taken
	mem[21] = skip;
	mem[22] = enc_b(13'h008, 5'd3, 5'd4, 3'b100);             // blt x4, x3 not taken
	mem[23] = enc_b(13'h008, 5'd4, 5'd3, 3'b111);             // bgeu x3, x4 taken
	mem[24] = skip;
	mem[25] = enc_j(21'h00000c, 5'd1);                        // jal x1, +12
	mem[26] = skip;
	mem[27] = skip;
	mem[28] = enc_i(12'h080, 5'd0, 3'b000, 5'd2, 7'b1100111); // jalr x2, 0x80(x0)
	mem[29] = skip;
	mem[30] = skip;
	mem[31] = skip;
	mem[32] = enc_s(12'h104, 5'd12, 5'd0);                    // sw x12, 0x104(x0)
	mem[33] = enc_i(12'h104, 5'd0, 3'b010, 5'd3, 7'b0000011); // lw x3, 0x104(x0)
	mem[34] = enc_i(12'h0ff, 5'd3, 3'b100, 5'd6, 7'b0010011); // xori x6, x3, 0xff
	mem[35] = 32'h00100073;                                   // ebreak

	// Retires in program order as pc, rd and the value written
	expect_retire(32'h00, 4'd1, 32'h12345000);
	expect_retire(32'h04, 4'd2, 32'h00001004);
	expect_retire(32'h08, 4'd3, 32'hfffffffb);
	expect_retire(32'h0c, 4'd4, 32'h00000007);
	expect_retire(32'h10, 4'd5, 32'h00000002);
	expect_retire(32'h14, 4'd6, 32'h0000000c);
	expect_retire(32'h18, 4'd7, 32'h12345000);
	expect_retire(32'h1c, 4'd8, 32'h00001007);
	expect_retire(32'h20, 4'd9, 32'h12345007);
	expect_retire(32'h24, 4'd10, 32'h00000001);
	expect_retire(32'h28, 4'd11, 32'h00000000);
	expect_retire(32'h2c, 4'd12, 32'h00000380);
	expect_retire(32'h30, 4'd13, 32'h01ffffff);
	expect_retire(32'h34, 4'd14, 32'hffffffff);
	expect_retire(32'h38, 4'd12, 32'h00000038);
	expect_retire(32'h3c, 4'd13, 32'hfffffffd);
	expect_retire(32'h40, 4'd0, 32'h00000000);
	expect_retire(32'h44, 4'd15, 32'h12345000);
	expect_retire(32'h48, 4'd0, 32'h00000000);
	expect_retire(32'h50, 4'd0, 32'h00000000);
	expect_retire(32'h58, 4'd0, 32'h00000000);
	expect_retire(32'h5c, 4'd0, 32'h00000000);
	expect_retire(32'h64, 4'd1, 32'h00000068);
	expect_retire(32'h70, 4'd2, 32'h00000074);
	expect_retire(32'h80, 4'd0, 32'h00000000);
	expect_retire(32'h84, 4'd3, 32'h00000038);
	expect_retire(32'h88, 4'd6, 32'h000000c7);

	// Stores in order as address and data
	expect_store(32'h100, 32'h12345000);
	expect_store(32'h104, 32'h00000038);
endtask

// ==== verif/core_tb.sv ====
module core_tb;
	import core_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT  = 40 * 3 * 10 + RESET_CYCLES;

	logic       clock;
	logic       rst;
	logic       mem_req_valid;
	logic       mem_req_ready;
	word_t      mem_req_addr;
	logic       mem_req_wen;
	word_t      mem_req_wdata;
	logic [3:0] mem_req_wstrb;
	logic       mem_resp_valid;
	word_t      mem_resp_data;
	logic       retire_valid;
	word_t      retire_pc;
	reg_idx_t   retire_rd;
	word_t      retire_val;
	logic       halted;
	logic       illegal;

	word_t      mem [256];
	word_t      exp_pc [64];
	reg_idx_t   exp_rd [64];
	word_t      exp_val [64];
	word_t      exp_addr [16];
	word_t      exp_data [16];
	int         retire_count = 0;
	int         store_count = 0;
	int         retire_idx = 0;
	int         store_idx = 0;
	int         cycles = 0;
	int         retire_errors = 0;
	int         store_errors = 0;
	int         stall_errors = 0;
	int         halt_errors = 0;
	int         end_errors = 0;
	int         accepted = 0;      // Requests taken by the memory model
	int         answered = 0;      // Requests whose delay has been scheduled
	word_t      resp_word;
	logic [1:0] delay;
	logic       pending;
	logic [31:0] lfsr = 32'h7a62;

	core_top #(.RESET_PC(32'h0), .REG_COUNT(16)) dut_i (
		.clock(clock),
		.rst(rst),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_addr(mem_req_addr),
		.mem_req_wen(mem_req_wen),
		.mem_req_wdata(mem_req_wdata),
		.mem_req_wstrb(mem_req_wstrb),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_val(retire_val),
		.halted(halted),
		.illegal(illegal)
	);

	function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic expect_retire(word_t pc, reg_idx_t rd, word_t val);
		exp_pc[retire_count]  = pc;
		exp_rd[retire_count]  = rd;
		exp_val[retire_count] = val;
		retire_count++;
	endtask

	task automatic expect_store(word_t addr, word_t data);
		exp_addr[store_count] = addr;
		exp_data[store_count] = data;
		store_count++;
	endtask

	`include "test_program.svh"

	// Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		return lfsr[0];
	endfunction

	always #4 clock = ~clock;

	// Memory model side that samples accepted requests and checks the outputs
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (!rst) begin
			if (mem_req_valid && mem_req_ready) begin
				assert (mem_req_addr < 32'd1024) else begin
					halt_errors++;
					$display("Request address %h is outside the memory", mem_req_addr);
				end
				if (mem_req_wen) begin
					mem[mem_req_addr[9:2]] = mem_req_wdata;
					assert (store_idx < store_count) else begin
						store_errors++;
						$display("Unexpected store to %h", mem_req_addr);
					end
					if (store_idx < store_count) begin
						assert (mem_req_addr == exp_addr[store_idx]) else begin
							store_errors++;
							$display("Fail store_addr[%0d] expected %h actual %h",
								store_idx, exp_addr[store_idx], mem_req_addr);
						end
						assert (mem_req_wdata == exp_data[store_idx]) else begin
							store_errors++;
							$display("Fail store_data[%0d] expected %h actual %h",
								store_idx, exp_data[store_idx], mem_req_wdata);
						end
						assert (mem_req_wstrb == 4'b1111) else begin
							store_errors++;
							$display("Fail store_strb[%0d] expected %h actual %h",
								store_idx, 4'b1111, mem_req_wstrb);
						end
					end
					store_idx++;
				end
				resp_word = mem[mem_req_addr[9:2]];
				accepted++;
			end
			if (retire_valid) begin
				assert (retire_idx < retire_count) else begin
					retire_errors++;
					$display("Instruction at %h retired beyond the table", retire_pc);
				end
				if (retire_idx < retire_count) begin
					assert (retire_pc == exp_pc[retire_idx]) else begin
						retire_errors++;
						$display("Fail retire_pc[%0d] expected %h actual %h",
							retire_idx, exp_pc[retire_idx], retire_pc);
					end
					assert (retire_rd == exp_rd[retire_idx]) else begin
						retire_errors++;
						$display("Fail retire_rd[%0d] expected %0d actual %0d",
							retire_idx, exp_rd[retire_idx], retire_rd);
					end
					assert (retire_val == exp_val[retire_idx]) else begin
						retire_errors++;
						$display("Fail retire_val[%0d] expected %h actual %h",
							retire_idx, exp_val[retire_idx], retire_val);
					end
				end
				retire_idx++;
			end
			assert (!illegal) else begin
				halt_errors++;
				$display("Core reported an illegal instruction");
			end
			if (halted) begin
				assert (!retire_valid && !mem_req_valid) else begin
					halt_errors++;
					$display("Core was still active after it halted");
				end
			end
		end
	end

	// Inputs change on the falling edge only
	always @(negedge clock) begin
		if (cycles <= RESET_CYCLES) begin  // Includes the edge that releases rst
			mem_req_ready  = 1'b0;
			mem_resp_valid = 1'b0;
			mem_resp_data  = '0;
			pending        = 1'b0;
			delay          = '0;
		end else begin
			mem_resp_valid = 1'b0;
			if (accepted != answered) begin
				answered++;
				pending = 1'b1;
				delay   = {next_bit(), next_bit()};  // One to four cycles
			end else if (pending && delay != 2'd0) begin
				delay = delay - 2'd1;
			end
			if (pending && delay == 2'd0) begin
				mem_resp_valid = 1'b1;
				mem_resp_data  = resp_word;
				pending        = 1'b0;
			end
			mem_req_ready = next_bit() | next_bit();
		end
	end

	assert property (@(posedge clock) disable iff (rst)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr) &&
		$stable(mem_req_wen) && $stable(mem_req_wdata) && $stable(mem_req_wstrb))
	else begin
		stall_errors++;
		$display("Memory request changed while it was stalled");
	end

	initial begin
		clock          = 1'b0;
		rst            = 1'b1;
		mem_req_ready  = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data  = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = {16'hdead, i[13:0], 2'b00};  // Low bits never form a valid opcode
		load_program();
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		while (!halted && cycles < CYCLE_LIMIT)
			@(posedge clock);
		if (!halted) begin
			end_errors++;
			$display("Timeout after %0d cycles without a halt", CYCLE_LIMIT);
		end else begin
			repeat (20) @(posedge clock);  // Quiet period after the halt
			assert (retire_idx == retire_count) else begin
				end_errors++;
				$display("Fail retire_total expected %0d actual %0d", retire_count, retire_idx);
			end
			assert (store_idx == store_count) else begin
				end_errors++;
				$display("Fail store_total expected %0d actual %0d", store_count, store_idx);
			end
		end
		$display("Errors: retire %0d, store %0d, stall %0d, halt %0d, end %0d",
			retire_errors, store_errors, stall_errors, halt_errors, end_errors);
		if (retire_errors + store_errors + stall_errors + halt_errors + end_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== source/core_top.sv ====
module core_top #(
	parameter core_pkg::word_t RESET_PC  = '0,
	parameter int              REG_COUNT = 16
) (
	input  logic               clock,
	input  logic               rst,

	output logic               mem_req_valid,
	input  logic               mem_req_ready,
	output core_pkg::word_t    mem_req_addr,
	output logic               mem_req_wen,
	output core_pkg::word_t    mem_req_wdata,
	output logic [3:0]         mem_req_wstrb,
	input  logic               mem_resp_valid,
	input  core_pkg::word_t    mem_resp_data,

	output logic               retire_valid,
	output core_pkg::word_t    retire_pc,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_val,
	output logic               halted,
	output logic               illegal
);
	import core_pkg::*;

	logic     inst_valid;
	logic     inst_ready;
	word_t    inst;
	word_t    inst_pc;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    rs1_val;
	word_t    rs2_val;
	logic     wb_done;
	logic     redirect_valid;
	word_t    redirect_pc;
	logic     reg_wen;
	reg_idx_t reg_waddr;
	word_t    reg_wdata;

	decode_if  dec_bus();
	exec_if    exe_bus();
	mem_bus_if ifu_mem();
	mem_bus_if lsu_mem();

	ifu #(.RESET_PC(RESET_PC)) my_ifu (
		.clock(clock),
		.rst(rst),
		.bus(ifu_mem),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst(inst),
		.inst_pc(inst_pc),
		.wb_done(wb_done),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc)
	);

	idu #(.REG_COUNT(REG_COUNT)) my_idu (
		.clock(clock),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst(inst),
		.inst_pc(inst_pc),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.dec(dec_bus),
		.halted(halted),
		.illegal(illegal)
	);

	regfile #(.REG_COUNT(REG_COUNT)) my_reg (
		.clock(clock),
		.rst(rst),
		.raddr1(rs1),
		.raddr2(rs2),
		.rdata1(rs1_val),
		.rdata2(rs2_val),
		.wen(reg_wen),
		.waddr(reg_waddr),
		.wdata(reg_wdata)
	);

	exu my_exu (
		.clock(clock),
		.rst(rst),
		.dec(dec_bus),
		.exe(exe_bus),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc)
	);

	lsu my_lsu (
		.clock(clock),
		.rst(rst),
		.exe(exe_bus),
		.bus(lsu_mem),
		.reg_wen(reg_wen),
		.reg_waddr(reg_waddr),
		.reg_wdata(reg_wdata),
		.wb_done(wb_done),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_val(retire_val)
	);

	mem_xbar my_xbar (
		.clock(clock),
		.rst(rst),
		.ifu_bus(ifu_mem),
		.lsu_bus(lsu_mem),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_addr(mem_req_addr),
		.mem_req_wen(mem_req_wen),
		.mem_req_wdata(mem_req_wdata),
		.mem_req_wstrb(mem_req_wstrb),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data)
	);

endmodule

// ==== source/mem_xbar.sv ====
module mem_xbar (
	input  logic            clock,
	input  logic            rst,
	mem_bus_if.slave        ifu_bus,
	mem_bus_if.slave        lsu_bus,
	output logic            mem_req_valid,
	input  logic            mem_req_ready,
	output core_pkg::word_t mem_req_addr,
	output logic            mem_req_wen,
	output core_pkg::word_t mem_req_wdata,
	output logic [3:0]      mem_req_wstrb,
	input  logic            mem_resp_valid,
	input  core_pkg::word_t mem_resp_data
);
	logic busy;       // One access is outstanding
	logic owner_lsu;
	logic pick_lsu;

	assign pick_lsu = lsu_bus.req_valid;  // The lsu wins a tie

	assign mem_req_valid = !busy && (ifu_bus.req_valid || lsu_bus.req_valid);
	assign mem_req_addr  = pick_lsu ? lsu_bus.addr : ifu_bus.addr;
	assign mem_req_wen   = pick_lsu ? lsu_bus.wen : ifu_bus.wen;
	assign mem_req_wdata = pick_lsu ? lsu_bus.wdata : ifu_bus.wdata;
	assign mem_req_wstrb = pick_lsu ? lsu_bus.wstrb : ifu_bus.wstrb;

	assign lsu_bus.req_ready = !busy && mem_req_ready;
	assign ifu_bus.req_ready = !busy && mem_req_ready && !pick_lsu;

	// Both masters see the data but only the owner sees the strobe
	assign ifu_bus.resp_valid = mem_resp_valid && busy && !owner_lsu;
	assign lsu_bus.resp_valid = mem_resp_valid && busy && owner_lsu;
	assign ifu_bus.rdata      = mem_resp_data;
	assign lsu_bus.rdata      = mem_resp_data;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy      <= 1'b0;
			owner_lsu <= 1'b0;
		end else if (mem_req_valid && mem_req_ready) begin
			busy      <= 1'b1;
			owner_lsu <= pick_lsu;
		end else if (mem_resp_valid) begin
			busy <= 1'b0;
		end
	end

	// A response with no access outstanding would reach neither master
	assert property (@(posedge clock) disable iff (rst)
		mem_resp_valid |-> busy);

endmodule

// ==== source/lsu.sv ====
module lsu (
	input  logic               clock,
	input  logic               rst,
	exec_if.consumer           exe,
	mem_bus_if.master          bus,
	output logic               reg_wen,
	output core_pkg::reg_idx_t reg_waddr,
	output core_pkg::word_t    reg_wdata,
	output logic               wb_done,
	output logic               retire_valid,
	output core_pkg::word_t    retire_pc,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_val
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		L_IDLE,
		L_REQ,
		L_WAIT
	} state_t;

	state_t   state;
	word_t    pc_q;
	reg_idx_t rd_q;
	logic     reg_wen_q;
	logic     wen_q;
	word_t    addr_q;
	word_t    wdata_q;
	word_t    val_q;
	logic     take;

	assign exe.ready = (state == L_IDLE);
	assign take      = exe.valid && exe.ready;

	assign bus.req_valid = (state == L_REQ);
	assign bus.addr      = addr_q;
	assign bus.wen       = wen_q;
	assign bus.wdata     = wdata_q;
	assign bus.wstrb     = 4'b1111;  // Word accesses only

	always_ff @(posedge clock) begin
		if (rst) begin
			state        <= L_IDLE;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= 1'b0;
			case (state)
				L_IDLE: begin
					if (take && (exe.mem_ren || exe.mem_wen))
						state <= L_REQ;
					else if (take)
						retire_valid <= 1'b1;
				end
				L_REQ: if (bus.req_ready) state <= L_WAIT;
				default: begin
					if (bus.resp_valid) begin
						state        <= L_IDLE;
						retire_valid <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			pc_q      <= exe.pc;
			rd_q      <= exe.rd;
			reg_wen_q <= exe.reg_wen;
			wen_q     <= exe.mem_wen;
			addr_q    <= exe.result;
			wdata_q   <= exe.store_data;
			val_q     <= (exe.wb_sel == WB_LINK) ? exe.link : exe.result;
		end else if (state == L_WAIT && bus.resp_valid && !wen_q) begin
			val_q <= bus.rdata;  // Load data replaces the address
		end
	end

	assign retire_pc  = pc_q;
	assign retire_rd  = rd_q;
	assign retire_val = reg_wen_q ? val_q : '0;
	assign reg_wen    = retire_valid && reg_wen_q;
	assign reg_waddr  = rd_q;
	assign reg_wdata  = val_q;
	assign wb_done    = retire_valid;

	assert property (@(posedge clock) disable iff (rst)
		bus.req_valid |-> bus.addr[1:0] == 2'b00);

endmodule

// ==== source/exu.sv ====
module exu (
	input  logic            clock,
	input  logic            rst,
	decode_if.consumer      dec,
	exec_if.producer        exe,
	output logic            redirect_valid,
	output core_pkg::word_t redirect_pc
);
	import core_pkg::*;

	word_t alu_out;
	word_t br_target;
	logic  cmp;
	logic  taken;
	logic  fire;

	assign dec.ready = !exe.valid || exe.ready;
	assign fire      = dec.valid && dec.ready;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:  alu_out = dec.op_a + dec.op_b;
			ALU_SUB:  alu_out = dec.op_a - dec.op_b;
			ALU_AND:  alu_out = dec.op_a & dec.op_b;
			ALU_OR:   alu_out = dec.op_a | dec.op_b;
			ALU_XOR:  alu_out = dec.op_a ^ dec.op_b;
			ALU_SLT:  alu_out = {31'b0, $signed(dec.op_a) < $signed(dec.op_b)};
			ALU_SLTU: alu_out = {31'b0, dec.op_a < dec.op_b};
			ALU_SLL:  alu_out = dec.op_a << dec.op_b[4:0];
			ALU_SRL:  alu_out = dec.op_a >> dec.op_b[4:0];
			ALU_SRA:  alu_out = $signed(dec.op_a) >>> dec.op_b[4:0];
			default:  alu_out = '0;
		endcase
	end

	// funct3 bit 0 inverts the test, so bne, bge and bgeu share a comparator
	always_comb begin
		case (dec.branch_funct[2:1])
			2'b00:   cmp = (dec.op_a == dec.rs2_val);
			2'b10:   cmp = $signed(dec.op_a) < $signed(dec.rs2_val);
			default: cmp = dec.op_a < dec.rs2_val;
		endcase
	end

	assign taken     = dec.is_branch && (cmp ^ dec.branch_funct[0]);
	assign br_target = dec.pc + dec.op_b;

	always_ff @(posedge clock) begin
		if (rst) begin
			exe.valid      <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			redirect_valid <= fire && (taken || dec.is_jump);
			if (fire)
				exe.valid <= 1'b1;
			else if (exe.ready)
				exe.valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			exe.pc         <= dec.pc;
			exe.result     <= alu_out;
			exe.link       <= dec.pc + 32'd4;
			exe.store_data <= dec.rs2_val;
			exe.rd         <= dec.rd;
			exe.reg_wen    <= dec.reg_wen;
			exe.mem_ren    <= dec.mem_ren;
			exe.mem_wen    <= dec.mem_wen;
			exe.wb_sel     <= dec.wb_sel;
			redirect_pc    <= dec.is_jump ? {alu_out[31:1], 1'b0} : br_target;
		end
	end

	// Catches a misaligned jump or branch before fetch issues it
	assert property (@(posedge clock) disable iff (rst)
		redirect_valid |-> redirect_pc[1:0] == 2'b00);

endmodule

// ==== source/regfile.sv ====
module regfile #(
	parameter int REG_COUNT = 16
) (
	input  logic               clock,
	input  logic               rst,
	input  core_pkg::reg_idx_t raddr1,
	input  core_pkg::reg_idx_t raddr2,
	output core_pkg::word_t    rdata1,
	output core_pkg::word_t    rdata2,
	input  logic               wen,
	input  core_pkg::reg_idx_t waddr,
	input  core_pkg::word_t    wdata
);
	import core_pkg::*;

	word_t regs [REG_COUNT];

	// x0 reads as zero whatever the array holds
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	always_ff @(posedge clock) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// Decode already drops writes to x0 and the index must name a real register
	assert property (@(posedge clock) disable iff (rst)
		wen |-> waddr != '0 && int'(waddr) < REG_COUNT);

endmodule

// ==== source/idu.sv ====
module idu #(
	parameter int REG_COUNT = 16
) (
	input  logic               clock,
	input  logic               rst,
	input  logic               inst_valid,
	output logic               inst_ready,
	input  core_pkg::word_t    inst,
	input  core_pkg::word_t    inst_pc,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	input  core_pkg::word_t    rs1_val,
	input  core_pkg::word_t    rs2_val,
	decode_if.producer         dec,
	output logic               halted,
	output logic               illegal
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd_f;
	logic [4:0] rs1_f;
	logic [4:0] rs2_f;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	alu_op_t    alu_f;
	logic       alu_ok;
	alu_op_t    d_alu;
	word_t      d_op_a;
	word_t      d_op_b;
	logic       d_branch;
	logic       d_jump;
	logic       d_ren;
	logic       d_wen;
	wb_sel_t    d_wb_sel;
	logic       d_reg_wen;
	logic       use_rs1;
	logic       use_rs2;
	logic       use_rd;
	logic       bad_enc;
	logic       bad_reg;
	logic       is_ebreak;
	logic       take;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd_f   = inst[11:7];
	assign rs1_f  = inst[19:15];
	assign rs2_f  = inst[24:20];
	assign rs1    = rs1_f[3:0];
	assign rs2    = rs2_f[3:0];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign is_ebreak = (opcode == OP_SYSTEM) && (inst[31:7] == 25'h0002000);

	always_comb begin
		case (funct3)
			3'b000: alu_f = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001: alu_f = ALU_SLL;
			3'b010: alu_f = ALU_SLT;
			3'b011: alu_f = ALU_SLTU;
			3'b100: alu_f = ALU_XOR;
			3'b101: alu_f = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110: alu_f = ALU_OR;
			default: alu_f = ALU_AND;
		endcase
	end

	// funct7 is part of the immediate except for register ops and shifts
	assign alu_ok = (opcode == OP_IMM && funct3 != 3'b001 && funct3 != 3'b101) ||
		funct7 == 7'h00 ||
		(funct7 == 7'h20 && (funct3 == 3'b101 || (opcode == OP_REG && funct3 == 3'b000)));

	always_comb begin
		d_alu    = ALU_ADD;
		d_op_a   = rs1_val;
		d_op_b   = imm_i;
		d_branch = 1'b0;
		d_jump   = 1'b0;
		d_ren    = 1'b0;
		d_wen    = 1'b0;
		d_wb_sel = WB_ALU;
		use_rs1  = 1'b0;
		use_rs2  = 1'b0;
		use_rd   = 1'b0;
		bad_enc  = 1'b0;
		case (opcode)
			OP_LUI: begin
				d_op_a = '0;
				d_op_b = imm_u;
				use_rd = 1'b1;
			end
			OP_AUIPC: begin
				d_op_a = inst_pc;
				d_op_b = imm_u;
				use_rd = 1'b1;
			end
			OP_JAL: begin
				d_op_a   = inst_pc;  // The ALU sum is the jump target
				d_op_b   = imm_j;
				d_jump   = 1'b1;
				d_wb_sel = WB_LINK;
				use_rd   = 1'b1;
			end
			OP_JALR: begin
				d_jump   = 1'b1;
				d_wb_sel = WB_LINK;
				use_rs1  = 1'b1;
				use_rd   = 1'b1;
				bad_enc  = (funct3 != 3'b000);
			end
			OP_BRANCH: begin
				d_op_b   = imm_b;    // Compare uses op_a and rs2_val
				d_branch = 1'b1;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
				bad_enc  = (funct3[2:1] == 2'b01);
			end
			OP_LOAD: begin
				d_ren    = 1'b1;
				d_wb_sel = WB_LOAD;
				use_rs1  = 1'b1;
				use_rd   = 1'b1;
				bad_enc  = (funct3 != 3'b010);  // Word loads only
			end
			OP_STORE: begin
				d_op_b  = imm_s;
				d_wen   = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				bad_enc = (funct3 != 3'b010);
			end
			OP_IMM: begin
				d_alu   = alu_f;
				use_rs1 = 1'b1;
				use_rd  = 1'b1;
				bad_enc = !alu_ok;
			end
			OP_REG: begin
				d_alu   = alu_f;
				d_op_b  = rs2_val;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rd  = 1'b1;
				bad_enc = !alu_ok;
			end
			default: bad_enc = !is_ebreak;
		endcase
	end

	assign bad_reg = (use_rs1 && int'(rs1_f) >= REG_COUNT) ||
		(use_rs2 && int'(rs2_f) >= REG_COUNT) ||
		(use_rd && int'(rd_f) >= REG_COUNT);
	assign d_reg_wen = use_rd && (rd_f != 5'd0);  // Writes to x0 are dropped here

	assign inst_ready = (!dec.valid || dec.ready) && !halted;
	assign take = inst_valid && inst_ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			dec.valid <= 1'b0;
			halted    <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			if (dec.valid && dec.ready)
				dec.valid <= 1'b0;
			if (take) begin
				if (is_ebreak || bad_enc || bad_reg) begin
					halted  <= 1'b1;
					illegal <= bad_enc || bad_reg;
				end else begin
					dec.valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			dec.pc           <= inst_pc;
			dec.alu_op       <= d_alu;
			dec.op_a         <= d_op_a;
			dec.op_b         <= d_op_b;
			dec.rs2_val      <= rs2_val;
			dec.rd           <= d_reg_wen ? rd_f[3:0] : '0;
			dec.reg_wen      <= d_reg_wen;
			dec.is_branch    <= d_branch;
			dec.branch_funct <= funct3;
			dec.is_jump      <= d_jump;
			dec.mem_ren      <= d_ren;
			dec.mem_wen      <= d_wen;
			dec.wb_sel       <= d_wb_sel;
		end
	end

endmodule

// ==== source/ifu.sv ====
module ifu #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input  logic            clock,
	input  logic            rst,
	mem_bus_if.master       bus,
	output logic            inst_valid,
	input  logic            inst_ready,
	output core_pkg::word_t inst,
	output core_pkg::word_t inst_pc,
	input  logic            wb_done,
	input  logic            redirect_valid,
	input  core_pkg::word_t redirect_pc
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		S_REQ,
		S_WAIT,
		S_HOLD
	} state_t;

	state_t state;
	word_t  pc;
	logic   boot;          // Acts as a wb_done for the first fetch
	logic   redir_seen;
	word_t  redir_target;

	assign bus.req_valid = (state == S_REQ);
	assign bus.addr      = pc;
	assign bus.wen       = 1'b0;  // Fetch only reads
	assign bus.wdata     = '0;
	assign bus.wstrb     = '0;
	assign inst_pc       = pc;

	always_ff @(posedge clock) begin
		if (rst) begin
			state      <= S_HOLD;
			boot       <= 1'b1;
			pc         <= RESET_PC;
			inst_valid <= 1'b0;
			redir_seen <= 1'b0;
		end else begin
			boot <= 1'b0;
			if (redirect_valid) begin
				redir_seen   <= 1'b1;
				redir_target <= redirect_pc;
			end
			case (state)
				S_REQ: if (bus.req_ready) state <= S_WAIT;
				S_WAIT: begin
					if (bus.resp_valid) begin
						state      <= S_HOLD;
						inst_valid <= 1'b1;
					end
				end
				default: begin
					if (inst_valid && inst_ready)
						inst_valid <= 1'b0;
					if (boot || wb_done)
						state <= S_REQ;
					// The instruction retired, so the next pc is now known
					if (wb_done) begin
						pc         <= redir_seen ? redir_target : pc + 32'd4;
						redir_seen <= 1'b0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_WAIT && bus.resp_valid)
			inst <= bus.rdata;
	end

	// With one instruction in flight, redirect and writeback only arrive while fetch holds
	assert property (@(posedge clock) disable iff (rst)
		wb_done || redirect_valid |-> state == S_HOLD);

endmodule

// ==== source/core_ifs.sv ====
interface decode_if;
	import core_pkg::*;

	logic       valid;
	logic       ready;
	word_t      pc;
	alu_op_t    alu_op;
	word_t      op_a;
	word_t      op_b;
	word_t      rs2_val;       // Store data, and the second branch operand
	reg_idx_t   rd;
	logic       reg_wen;
	logic       is_branch;
	logic [2:0] branch_funct;
	logic       is_jump;
	logic       mem_ren;
	logic       mem_wen;
	wb_sel_t    wb_sel;

	modport producer(output valid, pc, alu_op, op_a, op_b, rs2_val, rd, reg_wen,
		is_branch, branch_funct, is_jump, mem_ren, mem_wen, wb_sel, input ready);
	modport consumer(input valid, pc, alu_op, op_a, op_b, rs2_val, rd, reg_wen,
		is_branch, branch_funct, is_jump, mem_ren, mem_wen, wb_sel, output ready);
endinterface

interface exec_if;
	import core_pkg::*;

	logic     valid;
	logic     ready;
	word_t    pc;
	word_t    result;     // ALU output, also the memory address
	word_t    link;
	word_t    store_data;
	reg_idx_t rd;
	logic     reg_wen;
	logic     mem_ren;
	logic     mem_wen;
	wb_sel_t  wb_sel;

	modport producer(output valid, pc, result, link, store_data, rd, reg_wen,
		mem_ren, mem_wen, wb_sel, input ready);
	modport consumer(input valid, pc, result, link, store_data, rd, reg_wen,
		mem_ren, mem_wen, wb_sel, output ready);
endinterface

// One access at a time, and every accepted request gets one resp_valid pulse
interface mem_bus_if;
	import core_pkg::*;

	logic       req_valid;
	logic       req_ready;
	word_t      addr;
	logic       wen;
	word_t      wdata;
	logic [3:0] wstrb;
	logic       resp_valid;
	word_t      rdata;

	modport master(output req_valid, addr, wen, wdata, wstrb,
		input req_ready, resp_valid, rdata);
	modport slave(input req_valid, addr, wen, wdata, wstrb,
		output req_ready, resp_valid, rdata);
endinterface

// ==== source/core_pkg.sv ====
package core_pkg;

	typedef logic [31:0] word_t;     // Data, addresses and instruction words
	typedef logic [3:0]  reg_idx_t;  // RV32E has sixteen registers
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  wb_sel_t;

	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_AND  = 4'd2;
	localparam alu_op_t ALU_OR   = 4'd3;
	localparam alu_op_t ALU_XOR  = 4'd4;
	localparam alu_op_t ALU_SLT  = 4'd5;
	localparam alu_op_t ALU_SLTU = 4'd6;
	localparam alu_op_t ALU_SLL  = 4'd7;
	localparam alu_op_t ALU_SRL  = 4'd8;
	localparam alu_op_t ALU_SRA  = 4'd9;

	// Source of the value written back to rd
	localparam wb_sel_t WB_ALU  = 2'd0;
	localparam wb_sel_t WB_LINK = 2'd1;  // pc+4 for jal and jalr
	localparam wb_sel_t WB_LOAD = 2'd2;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

endpackage
